// ==== decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                bubble,
    input  mips_pkg::word_t     if_id_pc,
    input  mips_pkg::word_t     if_id_instr,
    output mips_pkg::reg_addr_t rf_raddr_a,
    output mips_pkg::reg_addr_t rf_raddr_b,
    input  mips_pkg::word_t     rf_rdata_a,
    input  mips_pkg::word_t     rf_rdata_b,
    input  logic                ex_wen,
    input  mips_pkg::reg_addr_t ex_dest,
    input  mips_pkg::word_t     ex_result,
    input  logic                mem_wen,
    input  mips_pkg::reg_addr_t mem_dest,
    input  mips_pkg::word_t     mem_result,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target,
    output mips_pkg::reg_addr_t id_rs,
    output mips_pkg::reg_addr_t id_rt,
    output mips_pkg::alu_op_e   id_ex_alu_op,
    output mips_pkg::word_t     id_ex_src_a,
    output mips_pkg::word_t     id_ex_src_b,
    output mips_pkg::word_t     id_ex_store_data,
    output mips_pkg::mem_op_e   id_ex_mem_op,
    output mips_pkg::reg_addr_t id_ex_dest,
    output logic                id_ex_wen
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm;
    word_t      rs_value;
    word_t      rt_value;
    word_t      imm_ext;
    word_t      pc_plus4;
    alu_op_e    alu_op;
    mem_op_e    mem_op;
    reg_addr_t  dest;
    logic       wen;
    logic       use_imm;
    logic       zero_ext;
    logic       use_shamt;

    assign opcode     = if_id_instr[31:26];
    assign funct      = if_id_instr[5:0];
    assign imm        = if_id_instr[15:0];
    assign id_rs      = if_id_instr[25:21];
    assign id_rt      = if_id_instr[20:16];
    assign rf_raddr_a = id_rs;
    assign rf_raddr_b = id_rt;

    forwarding_unit forward_rs (
        .reg_addr (id_rs),
        .reg_data (rf_rdata_a),
        .ex_wen   (ex_wen),
        .ex_dest  (ex_dest),
        .ex_data  (ex_result),
        .mem_wen  (mem_wen),
        .mem_dest (mem_dest),
        .mem_data (mem_result),
        .result   (rs_value)
    );

    forwarding_unit forward_rt (
        .reg_addr (id_rt),
        .reg_data (rf_rdata_b),
        .ex_wen   (ex_wen),
        .ex_dest  (ex_dest),
        .ex_data  (ex_result),
        .mem_wen  (mem_wen),
        .mem_dest (mem_dest),
        .mem_data (mem_result),
        .result   (rt_value)
    );

    always_comb begin
        alu_op    = ALU_ADD;
        mem_op    = MEM_NONE;
        dest      = id_rt;
        wen       = 1'b0;
        use_imm   = 1'b1;
        zero_ext  = 1'b0;
        use_shamt = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dest    = if_id_instr[15:11];
                wen     = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL: begin
                        alu_op    = ALU_SLL;
                        use_shamt = 1'b1;
                    end
                    default: wen = 1'b0;
                endcase
            end
            OP_ADDIU: wen = 1'b1;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                zero_ext = 1'b1;
                wen      = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
                wen      = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                wen    = 1'b1;
            end
            OP_LW: begin
                mem_op = MEM_LOAD;
                wen    = 1'b1;
            end
            OP_SW: mem_op = MEM_STORE;
            default: ;
        endcase
    end

    assign imm_ext  = zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign pc_plus4 = if_id_pc + 32'd4;

    // Resolved here, the delay slot is already in fetch
    assign branch_taken = (opcode == OP_BEQ && rs_value == rt_value)
                       || (opcode == OP_BNE && rs_value != rt_value)
                       || opcode == OP_J;
    assign branch_target = (opcode == OP_J) ? {pc_plus4[31:28], if_id_instr[25:0], 2'b00}
                                            : pc_plus4 + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset || (bubble && !stall)) begin
            id_ex_alu_op <= ALU_ADD;
            id_ex_mem_op <= MEM_NONE;
            id_ex_dest   <= '0;
            id_ex_wen    <= 1'b0;
        end else if (!stall) begin
            id_ex_alu_op <= alu_op;
            id_ex_mem_op <= mem_op;
            id_ex_dest   <= dest;
            id_ex_wen    <= wen && dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_ex_src_a      <= use_shamt ? {27'b0, if_id_instr[10:6]} : rs_value;
            id_ex_src_b      <= use_imm ? imm_ext : rt_value;
            id_ex_store_data <= rt_value;
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  mips_pkg::alu_op_e   id_ex_alu_op,
    input  mips_pkg::word_t     id_ex_src_a,
    input  mips_pkg::word_t     id_ex_src_b,
    input  mips_pkg::word_t     id_ex_store_data,
    input  mips_pkg::mem_op_e   id_ex_mem_op,
    input  mips_pkg::reg_addr_t id_ex_dest,
    input  logic                id_ex_wen,
    output mips_pkg::word_t     ex_result,
    output mips_pkg::word_t     ex_mem_result,
    output mips_pkg::word_t     ex_mem_store_data,
    output mips_pkg::mem_op_e   ex_mem_mem_op,
    output mips_pkg::reg_addr_t ex_mem_dest,
    output logic                ex_mem_wen
);
    import mips_pkg::*;

    // ADD also forms load and store addresses
    always_comb begin
        case (id_ex_alu_op)
            ALU_ADD: ex_result = id_ex_src_a + id_ex_src_b;
            ALU_SUB: ex_result = id_ex_src_a - id_ex_src_b;
            ALU_AND: ex_result = id_ex_src_a & id_ex_src_b;
            ALU_OR:  ex_result = id_ex_src_a | id_ex_src_b;
            ALU_XOR: ex_result = id_ex_src_a ^ id_ex_src_b;
            ALU_SLT: ex_result = {31'b0, $signed(id_ex_src_a) < $signed(id_ex_src_b)};
            ALU_SLL: ex_result = id_ex_src_b << id_ex_src_a[4:0];
            ALU_LUI: ex_result = {id_ex_src_b[15:0], 16'b0};
            default: ex_result = id_ex_src_a + id_ex_src_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem_mem_op <= MEM_NONE;
            ex_mem_dest   <= '0;
            ex_mem_wen    <= 1'b0;
        end else if (!stall) begin
            ex_mem_mem_op <= id_ex_mem_op;
            ex_mem_dest   <= id_ex_dest;
            ex_mem_wen    <= id_ex_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_mem_result     <= ex_result;
            ex_mem_store_data <= id_ex_store_data;
        end
    end

endmodule

// ==== forwarding_unit.sv ====
`timescale 1ns/10ps

module forwarding_unit (
    input  mips_pkg::reg_addr_t reg_addr,
    input  mips_pkg::word_t     reg_data,
    input  logic                ex_wen,
    input  mips_pkg::reg_addr_t ex_dest,
    input  mips_pkg::word_t     ex_data,
    input  logic                mem_wen,
    input  mips_pkg::reg_addr_t mem_dest,
    input  mips_pkg::word_t     mem_data,
    output mips_pkg::word_t     result
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wen && ex_dest == reg_addr && reg_addr != '0;
    assign mem_hit = mem_wen && mem_dest == reg_addr && reg_addr != '0;

    // Youngest producer wins
    always_comb begin
        if (ex_hit) begin
            result = ex_data;
        end else if (mem_hit) begin
            result = mem_data;
        end else begin
            result = reg_data;
        end
    end

endmodule

// ==== hazard_ctrl.sv ====
`timescale 1ns/10ps

module hazard_ctrl (
    input  logic                fetch_wait,
    input  logic                mem_wait,
    input  mips_pkg::reg_addr_t id_rs,
    input  mips_pkg::reg_addr_t id_rt,
    input  mips_pkg::mem_op_e   id_ex_mem_op,
    input  mips_pkg::reg_addr_t id_ex_dest,
    output logic                stall,
    output logic                bubble
);
    import mips_pkg::*;

    logic load_in_ex;

    // Either channel waiting freezes the whole pipeline
    assign stall = fetch_wait | mem_wait;

    // Load data only exists from MEM on, so decode waits one cycle
    assign load_in_ex = id_ex_mem_op == MEM_LOAD && id_ex_dest != '0;
    assign bubble     = load_in_ex && (id_ex_dest == id_rs || id_ex_dest == id_rt);

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  mips_pkg::word_t     ex_mem_result,
    input  mips_pkg::word_t     ex_mem_store_data,
    input  mips_pkg::mem_op_e   ex_mem_mem_op,
    input  mips_pkg::reg_addr_t ex_mem_dest,
    input  logic                ex_mem_wen,
    output logic                data_en,
    output logic [3:0]          data_wen,
    output mips_pkg::word_t     data_addr,
    output mips_pkg::word_t     data_wdata,
    input  logic                data_ok,
    input  mips_pkg::word_t     data_rdata,
    output logic                mem_wait,
    output mips_pkg::word_t     mem_result,
    output logic                wb_wen,
    output mips_pkg::reg_addr_t wb_dest,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    mem_state_e state;
    word_t      load_data;

    // Once answered, no new request until EX/MEM moves on
    assign data_en    = ex_mem_mem_op != MEM_NONE && state != MEM_DONE;
    assign data_wen   = (ex_mem_mem_op == MEM_STORE) ? WEN_WORD : 4'b0;
    assign data_addr  = ex_mem_result;
    assign data_wdata = ex_mem_store_data;
    assign mem_wait   = data_en & ~data_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE, MEM_WAIT: begin
                    if (data_en && data_ok) begin
                        state <= stall ? MEM_DONE : MEM_IDLE;
                    end else if (data_en) begin
                        state <= MEM_WAIT;
                    end
                end
                MEM_DONE: if (!stall) state <= MEM_IDLE;
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (data_en && data_ok) begin
            load_data <= data_rdata;
        end
    end

    always_comb begin
        if (ex_mem_mem_op != MEM_LOAD) begin
            mem_result = ex_mem_result;
        end else if (state == MEM_DONE) begin
            mem_result = load_data;
        end else begin
            mem_result = data_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_wen <= 1'b0;
        end else if (!stall) begin
            wb_wen <= ex_mem_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_dest <= ex_mem_dest;
            wb_data <= mem_result;
        end
    end

endmodule

// ==== mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

    typedef enum logic [1:0] {MEM_IDLE, MEM_WAIT, MEM_DONE} mem_state_e;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [3:0] WEN_WORD = 4'hf;

endpackage

// ==== pc_fetch.sv ====
`timescale 1ns/10ps

module pc_fetch #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            bubble,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    output logic            inst_en,
    output mips_pkg::word_t inst_addr,
    input  logic            inst_ok,
    input  mips_pkg::word_t inst_data,
    output logic            fetch_wait,
    output mips_pkg::word_t if_id_pc,
    output mips_pkg::word_t if_id_instr
);
    import mips_pkg::*;

    logic  running;
    logic  buf_valid;
    logic  word_ready;
    logic  advance;
    word_t pc;
    word_t buf_data;

    // No request in the first cycle out of reset
    assign inst_en    = running & ~buf_valid;
    assign inst_addr  = pc;
    assign word_ready = buf_valid | (inst_en & inst_ok);
    assign fetch_wait = ~word_ready;
    assign advance    = ~stall & ~bubble;

    always_ff @(posedge clk) begin
        if (reset) begin
            running     <= 1'b0;
            buf_valid   <= 1'b0;
            pc          <= reset_pc;
            if_id_pc    <= reset_pc;
            if_id_instr <= '0;
        end else begin
            running <= 1'b1;
            if (advance) begin
                buf_valid   <= 1'b0;
                if_id_pc    <= pc;
                if_id_instr <= buf_valid ? buf_data : inst_data;
                pc          <= branch_taken ? branch_target : pc + 32'd4;
            end else if (inst_en && inst_ok) begin
                buf_valid <= 1'b1;
            end
        end
    end

    // Word that arrived while the pipeline was held
    always_ff @(posedge clk) begin
        if (inst_en && inst_ok && !advance) begin
            buf_data <= inst_data;
        end
    end

endmodule

// ==== project.f ====
mips_pkg.sv
forwarding_unit.sv
register_file.sv
pc_fetch.sv
decode_stage.sv
hazard_ctrl.sv
execute_stage.sv
memory_stage.sv
sirius_core.sv
sirius_properties.sv
tb_sirius.sv

// ==== register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t raddr_a,
    input  mips_pkg::reg_addr_t raddr_b,
    output mips_pkg::word_t     rdata_a,
    output mips_pkg::word_t     rdata_b,
    input  logic                wen,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata
);
    import mips_pkg::*;

    word_t regs [32];

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // Falling edge write, decode reads the writeback value in the same cycle
    always_ff @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sirius -f project.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sirius_core.sv ====
`timescale 1ns/10ps

module sirius_core #(
    parameter mips_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            reset,
    output logic            inst_en,
    output mips_pkg::word_t inst_addr,
    input  logic            inst_ok,
    input  mips_pkg::word_t inst_data,
    output logic            data_en,
    output logic [3:0]      data_wen,
    output mips_pkg::word_t data_addr,
    output mips_pkg::word_t data_wdata,
    input  logic            data_ok,
    input  mips_pkg::word_t data_rdata
);
    import mips_pkg::*;

    logic      stall;
    logic      bubble;
    logic      fetch_wait;
    logic      mem_wait;
    logic      branch_taken;
    word_t     branch_target;
    word_t     if_id_pc;
    word_t     if_id_instr;
    reg_addr_t rf_raddr_a;
    reg_addr_t rf_raddr_b;
    word_t     rf_rdata_a;
    word_t     rf_rdata_b;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    alu_op_e   id_ex_alu_op;
    word_t     id_ex_src_a;
    word_t     id_ex_src_b;
    word_t     id_ex_store_data;
    mem_op_e   id_ex_mem_op;
    reg_addr_t id_ex_dest;
    logic      id_ex_wen;
    word_t     ex_result;
    word_t     ex_mem_result;
    word_t     ex_mem_store_data;
    mem_op_e   ex_mem_mem_op;
    reg_addr_t ex_mem_dest;
    logic      ex_mem_wen;
    word_t     mem_result;
    logic      wb_wen;
    reg_addr_t wb_dest;
    word_t     wb_data;

    pc_fetch #(.reset_pc(reset_pc)) pc_fetch0 (.*);

    register_file register_file0 (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b),
        .wen     (wb_wen),
        .waddr   (wb_dest),
        .wdata   (wb_data)
    );

    // EX forwarding from the ID/EX register, MEM forwarding from EX/MEM
    decode_stage decode_stage0 (
        .ex_wen   (id_ex_wen),
        .ex_dest  (id_ex_dest),
        .mem_wen  (ex_mem_wen),
        .mem_dest (ex_mem_dest),
        .*
    );

    hazard_ctrl hazard_ctrl0 (.*);

    execute_stage execute_stage0 (.*);

    memory_stage memory_stage0 (.*);

endmodule

// ==== sirius_properties.sv ====
`timescale 1ns/10ps

module sirius_properties (
    input logic        clk,
    input logic        reset,
    input logic        inst_en,
    input logic [31:0] inst_addr,
    input logic        inst_ok,
    input logic        data_en,
    input logic [3:0]  data_wen,
    input logic [31:0] data_addr,
    input logic [31:0] data_wdata,
    input logic        data_ok
);

    // Pending requests hold until answered
    inst_hold: assert property (@(posedge clk) disable iff (reset)
        inst_en && !inst_ok |=> inst_en && $stable(inst_addr))
        else $error("inst request changed before inst_ok");

    data_hold: assert property (@(posedge clk) disable iff (reset)
        data_en && !data_ok |=> data_en && $stable(data_addr)
            && $stable(data_wdata) && $stable(data_wen))
        else $error("data request changed before data_ok");

    quiet_after_reset: assert property (@(posedge clk) reset |=> !inst_en && !data_en)
        else $error("request raised right after reset");

endmodule

bind sirius_core sirius_properties props0 (.*);

// ==== sirius_testdata.txt ====
// Header: program length, store count, then padding to 16 words
// Program words from pc 0, then one expected store per line: address data
00000027 0000000f 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
24010005 2402fffd 00221821 ac030100 // ALU chain and first store
00222023 00822826 ac040104 ac050108
0041302a 00013900 00e54024 00c74825
ac06010c ac080110 ac090114 3c0a8001
354a8234 304b8f0f ac0a0118 ac0b011c
8c0c0104 01816821 ac0d0120 ac090124 // load-use
8c0e0124 ac0e0128 10220002 ac01012c // beq not taken
14220002 ac020130 ac0301fc 10840002 // bne taken, beq taken
ac040134 ac0301f8 08000025 ac070138 // j with delay slot
ac0301f4 08000025 00000000
00000100 00000002
00000104 00000008
00000108 fffffff5
0000010c 00000001
00000110 00000050
00000114 00000051
00000118 80018234
0000011c 00008f0d
00000120 0000000d
00000124 00000051
00000128 00000051
0000012c 00000005
00000130 fffffffd
00000134 00000008
00000138 00000050

// ==== tb_sirius.sv ====
`timescale 1ns/10ps

module tb_sirius;
    import mips_pkg::*;

    localparam int IMAGE_DEPTH = 128;
    localparam int DMEM_DEPTH  = 256;
    localparam int HEADER_LEN  = 16;

    logic        clk;
    logic        reset;
    logic        inst_en;
    word_t       inst_addr;
    logic        inst_ok;
    word_t       inst_data;
    logic        data_en;
    logic [3:0]  data_wen;
    word_t       data_addr;
    word_t       data_wdata;
    logic        data_ok;
    word_t       data_rdata;

    word_t       image [0:IMAGE_DEPTH-1];
    word_t       dmem [0:DMEM_DEPTH-1];
    logic [31:0] rng;
    int          iwait;
    int          dwait;
    int          prog_len;
    int          n_stores;
    int          store_count;
    int          exp_base;
    word_t       self_jump_addr;
    int          jump_fetches;

    sirius_core #(.reset_pc(32'h0)) dut0 (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Words past the program read as no-ops
    function automatic word_t fetch_word(input word_t addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < prog_len) begin
            return image[HEADER_LEN + idx];
        end
        return '0;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %08h actual %08h", name, expected, actual);
            abort_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Both memories answer after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        if (reset || !inst_en) begin
            inst_ok = 1'b0;
            iwait   = -1;
        end else begin
            if (iwait < 0) begin
                rng   = xorshift(rng);
                iwait = int'(rng[1:0]);
            end
            if (iwait == 0) begin
                inst_ok   = 1'b1;
                inst_data = fetch_word(inst_addr);
                iwait     = -1;
                if (inst_addr == self_jump_addr) begin
                    jump_fetches = jump_fetches + 1;
                end
            end else begin
                inst_ok = 1'b0;
                iwait   = iwait - 1;
            end
        end

        if (reset || !data_en) begin
            data_ok = 1'b0;
            dwait   = -1;
        end else begin
            if (dwait < 0) begin
                rng   = xorshift(rng);
                dwait = int'(rng[1:0]);
            end
            if (dwait == 0) begin
                data_ok = 1'b1;
                dwait   = -1;
                if (data_wen == WEN_WORD) begin
                    dmem[data_addr[9:2]] = data_wdata;
                    if (store_count < n_stores) begin
                        check_value($sformatf("store %0d address", store_count),
                                    image[exp_base + 2 * store_count], data_addr);
                        check_value($sformatf("store %0d data", store_count),
                                    image[exp_base + 2 * store_count + 1], data_wdata);
                    end
                    store_count = store_count + 1;
                end else begin
                    check_value("load write enables", 32'h0, {28'b0, data_wen});
                    data_rdata = dmem[data_addr[9:2]];
                end
            end else begin
                data_ok = 1'b0;
                dwait   = dwait - 1;
            end
        end
    end

    initial begin
        reset        = 1'b1;
        inst_ok      = 1'b0;
        inst_data    = '0;
        data_ok      = 1'b0;
        data_rdata   = '0;
        rng          = 32'h3f0;
        iwait        = -1;
        dwait        = -1;
        store_count  = 0;
        jump_fetches = 0;
        $readmemh("sirius_testdata.txt", image);
        prog_len       = int'(image[0]);
        n_stores       = int'(image[1]);
        exp_base       = HEADER_LEN + prog_len;
        self_jump_addr = word_t'((prog_len - 2) * 4);
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = 32'hdead0000 ^ (i * 32'h01010101);
        end
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        // Earlier stores have all left MEM by the third self-jump fetch
        wait (jump_fetches >= 3);
        if (store_count == n_stores) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Mismatch store count expected %0d actual %0d", n_stores, store_count);
            abort_run();
        end
    end

    initial begin
        #1;
        repeat (40 * prog_len + 200) @(posedge clk);
        $display("Timeout: only %0d of %0d stores seen", store_count, n_stores);
        abort_run();
    end

endmodule
